/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_ooo_core
RTL_TOP    ?= ooo_core
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation FAILED"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
rtl/core_pkg.sv
rtl/rename.sv
rtl/rob.sv
rtl/phys_regs.sv
rtl/issue_exec.sv
rtl/ooo_core.sv
dv/tb_ooo_core.sv

/* dv/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int ROB_DEPTH  = 8;
    localparam int IQ_DEPTH   = 4;
    localparam int WAIT_LIMIT = 200;

    logic                clk;
    logic                reset;
    logic                instr_valid;
    core_pkg::alu_op_t   instr_op;
    core_pkg::arch_reg_t instr_rd;
    core_pkg::arch_reg_t instr_rs1;
    core_pkg::arch_reg_t instr_rs2;
    core_pkg::word_t     instr_imm;
    logic                instr_ready;
    logic                retire_valid;
    core_pkg::arch_reg_t retire_rd;
    core_pkg::word_t     retire_value;

    // In-order architectural model and the retire stream it predicts
    core_pkg::word_t     model_regs [core_pkg::ARCH_REGS];
    core_pkg::arch_reg_t exp_rd [$];
    core_pkg::word_t     exp_value [$];

    int error_count;
    int pass_count;
    int fail_count;
    int test_start_errors;
    bit timed_out;
    bit stall_seen;

    ooo_core #(.ROB_DEPTH(ROB_DEPTH), .IQ_DEPTH(IQ_DEPTH)) dut (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr_op(instr_op), .instr_rd(instr_rd),
        .instr_rs1(instr_rs1), .instr_rs2(instr_rs2), .instr_imm(instr_imm),
        .instr_ready(instr_ready),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic core_pkg::word_t alu_model(input core_pkg::alu_op_t op,
                                                  input core_pkg::word_t a,
                                                  input core_pkg::word_t b,
                                                  input core_pkg::word_t imm);
        case (op)
            core_pkg::ALU_ADD:  return a + b;
            core_pkg::ALU_SUB:  return a - b;
            core_pkg::ALU_AND:  return a & b;
            core_pkg::ALU_OR:   return a | b;
            core_pkg::ALU_XOR:  return a ^ b;
            core_pkg::ALU_SLL:  return a << b[4:0];
            core_pkg::ALU_ADDI: return a + imm;
            default:            return imm;
        endcase
    endfunction

    task automatic record_accept(input core_pkg::alu_op_t op, input core_pkg::arch_reg_t rd,
                                 input core_pkg::arch_reg_t rs1,
                                 input core_pkg::arch_reg_t rs2,
                                 input core_pkg::word_t imm);
        core_pkg::word_t value;
        value = alu_model(op, model_regs[rs1], model_regs[rs2], imm);
        model_regs[rd] = value;
        exp_rd.push_back(rd);
        exp_value.push_back(value);
    endtask

    // Drive on the falling edge, then look at instr_ready while it is stable
    task automatic send_instr(input core_pkg::alu_op_t op, input core_pkg::arch_reg_t rd,
                              input core_pkg::arch_reg_t rs1, input core_pkg::arch_reg_t rs2,
                              input core_pkg::word_t imm);
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(negedge clk);
            instr_valid = 1'b1;
            instr_op    = op;
            instr_rd    = rd;
            instr_rs1   = rs1;
            instr_rs2   = rs2;
            instr_imm   = imm;
            #1;
            while (!instr_ready && waited < WAIT_LIMIT) begin
                stall_seen = 1'b1;
                @(negedge clk);
                #1;
                waited++;
            end
            if (instr_ready) begin
                record_accept(op, rd, rs1, rs2, imm);
            end else begin
                timed_out = 1'b1;
                $display("timeout at %0t: instr_ready stayed low for %0d cycles",
                         $time, WAIT_LIMIT);
            end
        end
    endtask

    task automatic send_random;
        send_instr(core_pkg::alu_op_t'(3'($urandom_range(0, 7))),
                   core_pkg::arch_reg_t'($urandom_range(0, 7)),
                   core_pkg::arch_reg_t'($urandom_range(0, 7)),
                   core_pkg::arch_reg_t'($urandom_range(0, 7)),
                   core_pkg::word_t'($urandom()));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain_retires;
        int waited;
        waited = 0;
        idle_cycles(1);
        #1;
        while (exp_rd.size() != 0 && waited < WAIT_LIMIT && !timed_out) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (exp_rd.size() != 0 && !timed_out) begin
            timed_out = 1'b1;
            $display("timeout at %0t: %0d instructions never retired", $time, exp_rd.size());
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        drain_retires();
        errs = error_count - test_start_errors;
        if (errs == 0 && !timed_out) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: FAIL, %0d errors", name, errs);
        end
        test_start_errors = error_count;
    endtask

    // Retire checker, sampled away from the rising edge
    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            if (exp_rd.size() == 0) begin
                error_count++;
                $display("retire at %0t with no instruction outstanding", $time);
            end else begin
                if (retire_rd !== exp_rd[0]) begin
                    error_count++;
                    $display("error at %0t: retire_rd = %0d, expected %0d",
                             $time, retire_rd, exp_rd[0]);
                end
                if (retire_value !== exp_value[0]) begin
                    error_count++;
                    $display("error at %0t: retire_value = 0x%08h, expected 0x%08h",
                             $time, retire_value, exp_value[0]);
                end
                void'(exp_rd.pop_front());
                void'(exp_value.pop_front());
            end
        end
    end

    initial begin
        core_pkg::arch_reg_t prev;
        core_pkg::arch_reg_t rd;
        core_pkg::arch_reg_t rs2;
        void'($urandom(60));
        reset             = 1'b1;
        instr_valid       = 1'b0;
        instr_op          = core_pkg::ALU_ADD;
        instr_rd          = '0;
        instr_rs1         = '0;
        instr_rs2         = '0;
        instr_imm         = '0;
        error_count       = 0;
        pass_count        = 0;
        fail_count        = 0;
        test_start_errors = 0;
        timed_out         = 1'b0;
        stall_seen        = 1'b0;
        for (int i = 0; i < core_pkg::ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet after reset, then sources that were never written
        repeat (10) begin
            @(negedge clk);
            #1;
            if (retire_valid !== 1'b0) begin
                error_count++;
                $display("error at %0t: retire_valid = %b, expected 0", $time, retire_valid);
            end
        end
        if (instr_ready !== 1'b1) begin
            error_count++;
            $display("error at %0t: instr_ready = %b, expected 1", $time, instr_ready);
        end
        send_instr(core_pkg::ALU_ADD, 3'd3, 3'd1, 3'd2, 32'h0);
        send_instr(core_pkg::ALU_SUB, 3'd4, 3'd0, 3'd7, 32'h0);
        send_instr(core_pkg::ALU_SLL, 3'd5, 3'd6, 3'd2, 32'h0);
        send_instr(core_pkg::ALU_ADDI, 3'd3, 3'd6, 3'd1, 32'h1234);
        send_instr(core_pkg::ALU_XOR, 3'd4, 3'd7, 3'd0, 32'h0);
        end_test("reset_state");

        repeat (20) begin
            send_instr(core_pkg::ALU_LI, core_pkg::arch_reg_t'($urandom_range(0, 7)),
                       3'd0, 3'd0, core_pkg::word_t'($urandom()));
        end
        end_test("independent_li");

        // Chains through every operation, some with a one-cycle gap
        send_instr(core_pkg::ALU_LI, 3'd1, 3'd0, 3'd0, core_pkg::word_t'($urandom()));
        send_instr(core_pkg::ALU_LI, 3'd2, 3'd0, 3'd0, core_pkg::word_t'($urandom()));
        prev = 3'd1;
        for (int k = 0; k < 48; k++) begin
            rd  = core_pkg::arch_reg_t'($urandom_range(0, 7));
            rs2 = (k % 2 == 0) ? prev : core_pkg::arch_reg_t'($urandom_range(0, 7));
            send_instr(core_pkg::alu_op_t'(3'(k % 8)), rd, prev, rs2,
                       core_pkg::word_t'($urandom()));
            if ($urandom_range(0, 2) == 0) begin
                idle_cycles(1);
            end
            prev = rd;
        end
        end_test("dependent_chains");

        stall_seen = 1'b0;
        for (int k = 0; k < 40; k++) begin
            send_instr(core_pkg::ALU_ADDI, 3'd1, 3'd1, 3'd0, core_pkg::word_t'($urandom()));
        end
        if (!stall_seen) begin
            error_count++;
            $display("instr_ready never dropped during the back-to-back burst");
        end
        end_test("backpressure_burst");

        for (int k = 0; k < 2000; k++) begin
            send_random();
            if ($urandom_range(0, 4) == 0) begin
                idle_cycles(int'($urandom_range(1, 3)));
            end
        end
        end_test("random_stream");

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    // Architectural and physical register file sizes
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 32;

    // Data word carried through the register file and ALU
    typedef logic [31:0] word_t;

    // Register indices
    typedef logic [2:0] arch_reg_t;
    typedef logic [4:0] phys_reg_t;

    // ALU operations
    // ADDI adds the immediate to rs1, LI takes the immediate alone,
    // SLL shifts by the low 5 bits of rs2
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLL  = 3'd5,
        ALU_ADDI = 3'd6,
        ALU_LI   = 3'd7
    } alu_op_t;

endpackage

/* rtl/issue_exec.sv */
`timescale 1ns/1ps

module issue_exec #(
    parameter int ROB_DEPTH = 8,
    parameter int IQ_DEPTH  = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         iq_alloc,
    input  core_pkg::alu_op_t            iq_op,
    input  core_pkg::word_t              iq_imm,
    input  core_pkg::phys_reg_t          iq_ps1,
    input  core_pkg::phys_reg_t          iq_ps2,
    input  logic                         iq_rdy1,
    input  logic                         iq_rdy2,
    input  core_pkg::phys_reg_t          iq_pd,
    input  logic [$clog2(ROB_DEPTH)-1:0] iq_tag,
    input  core_pkg::word_t              rd_data1,
    input  core_pkg::word_t              rd_data2,
    output logic                         iq_full,
    output core_pkg::phys_reg_t          rd_ps1,
    output core_pkg::phys_reg_t          rd_ps2,
    output logic                         wb_valid,
    output core_pkg::phys_reg_t          wb_preg,
    output core_pkg::word_t              wb_value,
    output logic [$clog2(ROB_DEPTH)-1:0] wb_tag
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int IDX_W = $clog2(IQ_DEPTH);

    logic [IQ_DEPTH-1:0] valid;
    logic [IQ_DEPTH-1:0] rdy1;
    logic [IQ_DEPTH-1:0] rdy2;
    core_pkg::alu_op_t   op [IQ_DEPTH];
    core_pkg::word_t     imm [IQ_DEPTH];
    core_pkg::phys_reg_t ps1 [IQ_DEPTH];
    core_pkg::phys_reg_t ps2 [IQ_DEPTH];
    core_pkg::phys_reg_t pd [IQ_DEPTH];
    logic [TAG_W-1:0]    tag [IQ_DEPTH];
    logic [IDX_W-1:0]    age [IQ_DEPTH];
    logic                sel_valid;
    logic [IDX_W-1:0]    sel;
    logic [IDX_W-1:0]    free_slot;
    logic [IDX_W-1:0]    new_age;
    core_pkg::word_t     result;

    assign iq_full = &valid;

    // Age counts the older entries still queued so the smallest is the oldest
    always_comb begin
        sel_valid = 1'b0;
        sel       = '0;
        free_slot = '0;
        new_age   = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_slot = IDX_W'(i);
            end else begin
                new_age = new_age + 1'b1;
            end
            if (valid[i] && rdy1[i] && rdy2[i] && (!sel_valid || age[i] < age[sel])) begin
                sel_valid = 1'b1;
                sel       = IDX_W'(i);
            end
        end
        // The issuing entry leaves on the same edge
        if (sel_valid) begin
            new_age = new_age - 1'b1;
        end
    end

    assign rd_ps1 = ps1[sel];
    assign rd_ps2 = ps2[sel];

    always_comb begin
        case (op[sel])
            core_pkg::ALU_ADD:  result = rd_data1 + rd_data2;
            core_pkg::ALU_SUB:  result = rd_data1 - rd_data2;
            core_pkg::ALU_AND:  result = rd_data1 & rd_data2;
            core_pkg::ALU_OR:   result = rd_data1 | rd_data2;
            core_pkg::ALU_XOR:  result = rd_data1 ^ rd_data2;
            core_pkg::ALU_SLL:  result = rd_data1 << rd_data2[4:0];
            core_pkg::ALU_ADDI: result = rd_data1 + imm[sel];
            core_pkg::ALU_LI:   result = imm[sel];
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= '0;
            wb_valid <= 1'b0;
        end else begin
            if (sel_valid) begin
                valid[sel] <= 1'b0;
            end
            if (iq_alloc) begin
                valid[free_slot] <= 1'b1;
            end
            wb_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            // Wakeup from the writeback bus
            if (wb_valid && wb_preg == ps1[i]) begin
                rdy1[i] <= 1'b1;
            end
            if (wb_valid && wb_preg == ps2[i]) begin
                rdy2[i] <= 1'b1;
            end
            if (sel_valid && valid[i] && age[i] > age[sel]) begin
                age[i] <= age[i] - 1'b1;
            end
        end
        if (iq_alloc) begin
            op[free_slot]   <= iq_op;
            imm[free_slot]  <= iq_imm;
            ps1[free_slot]  <= iq_ps1;
            ps2[free_slot]  <= iq_ps2;
            rdy1[free_slot] <= iq_rdy1;
            rdy2[free_slot] <= iq_rdy2;
            pd[free_slot]   <= iq_pd;
            tag[free_slot]  <= iq_tag;
            age[free_slot]  <= new_age;
        end
        wb_value <= result;
        wb_preg  <= pd[sel];
        wb_tag   <= tag[sel];
    end

endmodule

/* rtl/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core #(
    parameter int ROB_DEPTH = 8,
    parameter int IQ_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  core_pkg::alu_op_t   instr_op,
    input  core_pkg::arch_reg_t instr_rd,
    input  core_pkg::arch_reg_t instr_rs1,
    input  core_pkg::arch_reg_t instr_rs2,
    input  core_pkg::word_t     instr_imm,
    output logic                instr_ready,
    output logic                retire_valid,
    output core_pkg::arch_reg_t retire_rd,
    output core_pkg::word_t     retire_value
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // Rename to ROB
    logic                rob_alloc;
    logic                rob_full;
    logic [TAG_W-1:0]    rob_tag;
    core_pkg::phys_reg_t rob_pd_new;
    core_pkg::phys_reg_t rob_pd_old;
    core_pkg::arch_reg_t rob_rd;

    // Rename to issue queue
    logic                iq_alloc;
    logic                iq_full;
    core_pkg::alu_op_t   iq_op;
    core_pkg::word_t     iq_imm;
    core_pkg::phys_reg_t iq_ps1;
    core_pkg::phys_reg_t iq_ps2;
    logic                iq_rdy1;
    logic                iq_rdy2;
    core_pkg::phys_reg_t iq_pd;
    logic [TAG_W-1:0]    iq_tag;

    // Readiness lookup and busy marking
    core_pkg::phys_reg_t query_ps1;
    core_pkg::phys_reg_t query_ps2;
    logic                ps1_ready;
    logic                ps2_ready;
    logic                set_busy;
    core_pkg::phys_reg_t busy_reg;

    // Writeback bus, operand reads and retire
    logic                wb_valid;
    core_pkg::phys_reg_t wb_preg;
    core_pkg::word_t     wb_value;
    logic [TAG_W-1:0]    wb_tag;
    core_pkg::phys_reg_t rd_ps1;
    core_pkg::phys_reg_t rd_ps2;
    core_pkg::word_t     rd_data1;
    core_pkg::word_t     rd_data2;
    logic                free_valid;
    core_pkg::phys_reg_t free_preg;
    core_pkg::phys_reg_t retire_preg;

    rename #(.ROB_DEPTH(ROB_DEPTH), .IQ_DEPTH(IQ_DEPTH)) u_rename (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr_op(instr_op), .instr_rd(instr_rd),
        .instr_rs1(instr_rs1), .instr_rs2(instr_rs2), .instr_imm(instr_imm),
        .instr_ready(instr_ready),
        .rob_full(rob_full), .rob_tag(rob_tag), .iq_full(iq_full),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready),
        .wb_valid(wb_valid), .wb_preg(wb_preg),
        .free_valid(free_valid), .free_preg(free_preg),
        .rob_alloc(rob_alloc), .rob_pd_new(rob_pd_new), .rob_pd_old(rob_pd_old),
        .rob_rd(rob_rd),
        .iq_alloc(iq_alloc), .iq_op(iq_op), .iq_imm(iq_imm),
        .iq_ps1(iq_ps1), .iq_ps2(iq_ps2), .iq_rdy1(iq_rdy1), .iq_rdy2(iq_rdy2),
        .iq_pd(iq_pd), .iq_tag(iq_tag),
        .query_ps1(query_ps1), .query_ps2(query_ps2),
        .set_busy(set_busy), .busy_reg(busy_reg)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .reset(reset),
        .rob_alloc(rob_alloc), .rob_pd_new(rob_pd_new), .rob_pd_old(rob_pd_old),
        .rob_rd(rob_rd), .wb_valid(wb_valid), .wb_tag(wb_tag),
        .rob_tag(rob_tag), .rob_full(rob_full),
        .free_valid(free_valid), .free_preg(free_preg),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_preg(retire_preg)
    );

    phys_regs u_phys_regs (
        .clk(clk), .reset(reset),
        .rd_ps1(rd_ps1), .rd_ps2(rd_ps2),
        .query_ps1(query_ps1), .query_ps2(query_ps2),
        .set_busy(set_busy), .busy_reg(busy_reg),
        .wb_valid(wb_valid), .wb_preg(wb_preg), .wb_value(wb_value),
        .retire_preg(retire_preg),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready),
        .retire_value(retire_value)
    );

    issue_exec #(.ROB_DEPTH(ROB_DEPTH), .IQ_DEPTH(IQ_DEPTH)) u_issue_exec (
        .clk(clk), .reset(reset),
        .iq_alloc(iq_alloc), .iq_op(iq_op), .iq_imm(iq_imm),
        .iq_ps1(iq_ps1), .iq_ps2(iq_ps2), .iq_rdy1(iq_rdy1), .iq_rdy2(iq_rdy2),
        .iq_pd(iq_pd), .iq_tag(iq_tag),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .iq_full(iq_full), .rd_ps1(rd_ps1), .rd_ps2(rd_ps2),
        .wb_valid(wb_valid), .wb_preg(wb_preg), .wb_value(wb_value), .wb_tag(wb_tag)
    );

endmodule

/* rtl/phys_regs.sv */
`timescale 1ns/1ps

module phys_regs (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::phys_reg_t rd_ps1,
    input  core_pkg::phys_reg_t rd_ps2,
    input  core_pkg::phys_reg_t query_ps1,
    input  core_pkg::phys_reg_t query_ps2,
    input  logic                set_busy,
    input  core_pkg::phys_reg_t busy_reg,
    input  logic                wb_valid,
    input  core_pkg::phys_reg_t wb_preg,
    input  core_pkg::word_t     wb_value,
    input  core_pkg::phys_reg_t retire_preg,
    output core_pkg::word_t     rd_data1,
    output core_pkg::word_t     rd_data2,
    output logic                ps1_ready,
    output logic                ps2_ready,
    output core_pkg::word_t     retire_value
);

    core_pkg::word_t              regs [core_pkg::PHYS_REGS];
    logic [core_pkg::PHYS_REGS-1:0] ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Initial mappings start at zero
            for (int i = 0; i < core_pkg::ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (set_busy) begin
                ready[busy_reg] <= 1'b0;
            end
            if (wb_valid) begin
                regs[wb_preg]  <= wb_value;
                ready[wb_preg] <= 1'b1;
            end
        end
    end

    assign rd_data1     = regs[rd_ps1];
    assign rd_data2     = regs[rd_ps2];
    assign retire_value = regs[retire_preg];
    assign ps1_ready    = ready[query_ps1];
    assign ps2_ready    = ready[query_ps2];

    // A freshly allocated register cannot have a result in flight
    assert property (@(posedge clk) disable iff (reset)
        set_busy && wb_valid |-> busy_reg != wb_preg);

endmodule

/* rtl/rename.sv */
`timescale 1ns/1ps

module rename #(
    parameter int ROB_DEPTH = 8,
    parameter int IQ_DEPTH  = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         instr_valid,
    input  core_pkg::alu_op_t            instr_op,
    input  core_pkg::arch_reg_t          instr_rd,
    input  core_pkg::arch_reg_t          instr_rs1,
    input  core_pkg::arch_reg_t          instr_rs2,
    input  core_pkg::word_t              instr_imm,
    output logic                         instr_ready,
    input  logic                         rob_full,
    input  logic [$clog2(ROB_DEPTH)-1:0] rob_tag,
    input  logic                         iq_full,
    input  logic                         ps1_ready,
    input  logic                         ps2_ready,
    input  logic                         wb_valid,
    input  core_pkg::phys_reg_t          wb_preg,
    input  logic                         free_valid,
    input  core_pkg::phys_reg_t          free_preg,
    output logic                         rob_alloc,
    output core_pkg::phys_reg_t          rob_pd_new,
    output core_pkg::phys_reg_t          rob_pd_old,
    output core_pkg::arch_reg_t          rob_rd,
    output logic                         iq_alloc,
    output core_pkg::alu_op_t            iq_op,
    output core_pkg::word_t              iq_imm,
    output core_pkg::phys_reg_t          iq_ps1,
    output core_pkg::phys_reg_t          iq_ps2,
    output logic                         iq_rdy1,
    output logic                         iq_rdy2,
    output core_pkg::phys_reg_t          iq_pd,
    output logic [$clog2(ROB_DEPTH)-1:0] iq_tag,
    output core_pkg::phys_reg_t          query_ps1,
    output core_pkg::phys_reg_t          query_ps2,
    output logic                         set_busy,
    output core_pkg::phys_reg_t          busy_reg
);

    localparam int FREE_REGS = core_pkg::PHYS_REGS - core_pkg::ARCH_REGS;
    localparam int CNT_W     = $clog2(core_pkg::PHYS_REGS) + 1;

    core_pkg::phys_reg_t map_table [core_pkg::ARCH_REGS];
    core_pkg::phys_reg_t free_list [core_pkg::PHYS_REGS];
    core_pkg::phys_reg_t fl_head;
    core_pkg::phys_reg_t fl_tail;
    logic [CNT_W-1:0]    fl_count;
    logic                accept;
    logic                src1_used;
    logic                src2_used;

    // Every in-flight instruction holds one free register
    if (ROB_DEPTH > FREE_REGS) begin : g_rob_check
        $error("ROB_DEPTH exceeds the number of free physical registers");
    end
    if (IQ_DEPTH < 2) begin : g_iq_check
        $error("IQ_DEPTH must be at least 2");
    end

    assign instr_ready = (fl_count != '0) && !rob_full && !iq_full;
    assign accept      = instr_valid && instr_ready;

    // LI has no sources and ADDI has no second source
    assign src1_used = instr_op != core_pkg::ALU_LI;
    assign src2_used = src1_used && (instr_op != core_pkg::ALU_ADDI);

    assign query_ps1 = map_table[instr_rs1];
    assign query_ps2 = map_table[instr_rs2];

    // Catch a wakeup that lands on the same edge as the queue write
    assign iq_rdy1 = !src1_used || ps1_ready || (wb_valid && wb_preg == query_ps1);
    assign iq_rdy2 = !src2_used || ps2_ready || (wb_valid && wb_preg == query_ps2);

    assign iq_alloc   = accept;
    assign iq_op      = instr_op;
    assign iq_imm     = instr_imm;
    assign iq_ps1     = query_ps1;
    assign iq_ps2     = query_ps2;
    assign iq_pd      = free_list[fl_head];
    assign iq_tag     = rob_tag;
    assign rob_alloc  = accept;
    assign rob_pd_new = free_list[fl_head];
    assign rob_pd_old = map_table[instr_rd];
    assign rob_rd     = instr_rd;
    assign set_busy   = accept;
    assign busy_reg   = free_list[fl_head];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map with the remaining registers queued as free
            for (int i = 0; i < core_pkg::ARCH_REGS; i++) begin
                map_table[i] <= core_pkg::phys_reg_t'(i);
            end
            for (int i = 0; i < core_pkg::PHYS_REGS; i++) begin
                free_list[i] <= core_pkg::phys_reg_t'(i + core_pkg::ARCH_REGS);
            end
            fl_head  <= '0;
            fl_tail  <= core_pkg::phys_reg_t'(FREE_REGS);
            fl_count <= CNT_W'(FREE_REGS);
        end else begin
            if (accept) begin
                map_table[instr_rd] <= free_list[fl_head];
                fl_head             <= fl_head + 1'b1;
            end
            if (free_valid) begin
                free_list[fl_tail] <= free_preg;
                fl_tail            <= fl_tail + 1'b1;
            end
            case ({free_valid, accept})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    // A released register always finds room on the free list
    assert property (@(posedge clk) disable iff (reset)
        free_valid |-> fl_count < CNT_W'(FREE_REGS));

endmodule

/* rtl/rob.sv */
`timescale 1ns/1ps

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rob_alloc,
    input  core_pkg::phys_reg_t          rob_pd_new,
    input  core_pkg::phys_reg_t          rob_pd_old,
    input  core_pkg::arch_reg_t          rob_rd,
    input  logic                         wb_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] wb_tag,
    output logic [$clog2(ROB_DEPTH)-1:0] rob_tag,
    output logic                         rob_full,
    output logic                         free_valid,
    output core_pkg::phys_reg_t          free_preg,
    output logic                         retire_valid,
    output core_pkg::arch_reg_t          retire_rd,
    output core_pkg::phys_reg_t          retire_preg
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] done;
    core_pkg::phys_reg_t  pd_new [ROB_DEPTH];
    core_pkg::phys_reg_t  pd_old [ROB_DEPTH];
    core_pkg::arch_reg_t  rd_arch [ROB_DEPTH];
    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;
    logic [TAG_W:0]       count;
    logic                 retire;

    assign retire   = valid[head] && done[head];
    assign rob_tag  = tail;
    assign rob_full = count == (TAG_W + 1)'(ROB_DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid        <= '0;
            done         <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            retire_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            if (rob_alloc) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= tail + 1'b1;
            end
            if (wb_valid) begin
                done[wb_tag] <= 1'b1;
            end
            // Head retires once its result is written back
            if (retire) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            retire_valid <= retire;
            free_valid   <= retire;
            case ({rob_alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            pd_new[tail]  <= rob_pd_new;
            pd_old[tail]  <= rob_pd_old;
            rd_arch[tail] <= rob_rd;
        end
        if (retire) begin
            retire_rd   <= rd_arch[head];
            retire_preg <= pd_new[head];
            free_preg   <= pd_old[head];
        end
    end

    assert property (@(posedge clk) disable iff (reset) rob_alloc |-> !rob_full);

    // Each instruction writes back exactly once, while it is still in flight
    assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> valid[wb_tag] && !done[wb_tag]);

endmodule
